// File: all.f
rtl/rotator_pkg.sv
rtl/weight_bank.sv
rtl/write_ctrl.sv
rtl/rotation_counters.sv
rtl/read_ctrl.sv
rtl/weight_rotator.sv
verification/rotator_checker.sv
verification/tb_weight_rotator.sv

// File: rtl/read_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read FSM, read bank index, done_read flags and output valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module read_ctrl
  import rotator_pkg::*;
(
  input  wire logic          aclk,
  input  wire logic          i_rst,
  input  wire logic [1:0]    i_done_write,
  output logic [1:0]         o_done_read,
  input  wire header_t [1:0] i_headers,
  input  wire logic          i_m_ready,
  output logic               o_m_valid,
  output logic               o_m_last,
  output user_t              o_m_user,
  output logic [1:0]         o_rready,
  output logic               o_read_bank
);

  read_state_e state;
  read_state_e state_next;
  logic        rd_idx;
  logic        m_hs;
  logic        cnt_last;

  assign o_read_bank = rd_idx;
  assign o_m_valid   = (state == R_READ);
  assign m_hs        = o_m_valid && i_m_ready;
  assign o_m_last    = o_m_valid && cnt_last;
  // Only the bank being read sees the output ready
  assign o_rready    = m_hs ? (rd_idx ? 2'b10 : 2'b01) : 2'b00;

  always_comb begin
    state_next = state;
    unique case (state)
      R_IDLE:   if (i_done_write[rd_idx]) state_next = R_READ;
      R_READ:   if (m_hs && cnt_last) state_next = R_SWITCH;
      R_SWITCH: state_next = R_IDLE;
      default:  state_next = R_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state       <= R_IDLE;
      rd_idx      <= 1'b0;
      o_done_read <= 2'b11;
    end else begin
      state <= state_next;
      if (state == R_IDLE && i_done_write[rd_idx]) begin
        o_done_read[rd_idx] <= 1'b0;
      end
      if (state == R_SWITCH) begin
        o_done_read[rd_idx] <= 1'b1;
        rd_idx              <= ~rd_idx;
      end
    end
  end

  // Counters keep reloading while idle, so they hold the final header on R_READ
  rotation_counters u_counters (
    .aclk     (aclk),
    .i_rst    (i_rst),
    .i_load   (state == R_IDLE),
    .i_step   (m_hs),
    .i_header (i_headers[rd_idx]),
    .o_last   (cnt_last),
    .o_user   (o_m_user)
  );

endmodule

`default_nettype wire

// File: rtl/rotation_counters.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nested kh/cin/cols/blocks down-counters with TLAST and user flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rotation_counters
  import rotator_pkg::*;
(
  input  wire logic    aclk,
  input  wire logic    i_rst,
  input  wire logic    i_load,
  input  wire logic    i_step,
  input  wire header_t i_header,
  output logic         o_last,
  output user_t        o_user
);

  header_t                ref_hdr;
  logic [BITS_KH-1:0]     cnt_kh;
  logic [BITS_CIN-1:0]    cnt_cin;
  logic [BITS_COLS-1:0]   cnt_cols;
  logic [BITS_BLOCKS-1:0] cnt_blocks;
  logic                   last_kh;
  logic                   last_cin;
  logic                   last_cols;
  logic                   last_blocks;
  logic                   en_cin;
  logic                   en_cols;
  logic                   en_blocks;

  // kh is innermost, each outer counter steps when all inner ones wrap
  assign en_cin    = i_step && last_kh;
  assign en_cols   = en_cin && last_cin;
  assign en_blocks = en_cols && last_cols;

  always_ff @(posedge aclk) begin
    if (i_load) begin
      ref_hdr <= i_header;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Down-counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Each last flag is registered, set when the count is about to reach 0
  // or at once when the minus-one size is itself 0
  always_ff @(posedge aclk) begin
    if (i_rst) begin
      cnt_kh      <= '0;
      cnt_cin     <= '0;
      cnt_cols    <= '0;
      cnt_blocks  <= '0;
      last_kh     <= 1'b0;
      last_cin    <= 1'b0;
      last_cols   <= 1'b0;
      last_blocks <= 1'b0;
    end else if (i_load) begin
      cnt_kh      <= i_header.kh_1;
      cnt_cin     <= i_header.cin_1;
      cnt_cols    <= i_header.cols_1;
      cnt_blocks  <= i_header.blocks_1;
      last_kh     <= (i_header.kh_1 == '0);
      last_cin    <= (i_header.cin_1 == '0);
      last_cols   <= (i_header.cols_1 == '0);
      last_blocks <= (i_header.blocks_1 == '0);
    end else begin
      if (i_step) begin
        cnt_kh  <= last_kh ? ref_hdr.kh_1 : cnt_kh - 1'b1;
        last_kh <= last_kh ? (ref_hdr.kh_1 == '0) : (cnt_kh == BITS_KH'(1));
      end
      if (en_cin) begin
        cnt_cin  <= last_cin ? ref_hdr.cin_1 : cnt_cin - 1'b1;
        last_cin <= last_cin ? (ref_hdr.cin_1 == '0) : (cnt_cin == BITS_CIN'(1));
      end
      if (en_cols) begin
        cnt_cols  <= last_cols ? ref_hdr.cols_1 : cnt_cols - 1'b1;
        last_cols <= last_cols ? (ref_hdr.cols_1 == '0) : (cnt_cols == BITS_COLS'(1));
      end
      if (en_blocks) begin
        cnt_blocks  <= last_blocks ? ref_hdr.blocks_1 : cnt_blocks - 1'b1;
        last_blocks <= last_blocks ? (ref_hdr.blocks_1 == '0) : (cnt_blocks == BITS_BLOCKS'(1));
      end
    end
  end

  assign o_last = last_kh && last_cin && last_cols && last_blocks;

  always_comb begin
    o_user.kw_1         = ref_hdr.kw_1;
    o_user.kh_1         = ref_hdr.kh_1;
    o_user.is_1x1       = (ref_hdr.kw_1 == '0);
    o_user.is_top       = (cnt_blocks == ref_hdr.blocks_1);
    o_user.is_bottom    = last_blocks;
    // Remaining columns equal to half the kernel width
    o_user.is_cols_1_k2 = (cnt_cols == BITS_COLS'(ref_hdr.kw_1 >> 1));
  end

endmodule

`default_nettype wire

// File: rtl/rotator_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight rotator field widths, header and user structs, FSM state types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rotator_pkg;

  // Kernel sizes are odd so that kw_1/2 gives the kernel centre
  localparam int KERNEL_W_MAX  = 3;
  localparam int KERNEL_H_MAX  = 3;
  localparam int IM_CIN_MAX    = 64;
  localparam int IM_COLS_MAX   = 32;
  localparam int IM_BLOCKS_MAX = 8;

  localparam int BITS_KW     = $clog2(KERNEL_W_MAX);
  localparam int BITS_KH     = $clog2(KERNEL_H_MAX);
  localparam int BITS_CIN    = $clog2(IM_CIN_MAX);
  localparam int BITS_COLS   = $clog2(IM_COLS_MAX);
  localparam int BITS_BLOCKS = $clog2(IM_BLOCKS_MAX);

  // One bank word per kernel row per input channel
  localparam int BANK_DEPTH = KERNEL_H_MAX * IM_CIN_MAX;
  localparam int BITS_ADDR  = $clog2(BANK_DEPTH);

  // Sits in the low bits of the first beat of a frame
  typedef struct packed {
    logic [BITS_BLOCKS-1:0] blocks_1;
    logic [BITS_COLS-1:0]   cols_1;
    logic [BITS_CIN-1:0]    cin_1;
    logic [BITS_KH-1:0]     kh_1;
    logic [BITS_KW-1:0]     kw_1;
  } header_t;

  typedef struct packed {
    logic [BITS_KW-1:0] kw_1;
    logic [BITS_KH-1:0] kh_1;
    logic               is_1x1;
    logic               is_top;
    logic               is_bottom;
    logic               is_cols_1_k2;
  } user_t;

  typedef enum logic [2:0] {W_IDLE, W_GET_REF, W_WRITE, W_FILL, W_SWITCH} write_state_e;
  typedef enum logic [1:0] {R_IDLE, R_READ, R_SWITCH} read_state_e;

endpackage

`default_nettype wire

// File: rtl/weight_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cyclic weight bank with write pointer and prefetched rotating read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module weight_bank
  import rotator_pkg::*;
#(
  parameter int  CORES      = 2,
  parameter int  WORD_WIDTH = 8,
  localparam int DATA_W     = WORD_WIDTH * CORES * KERNEL_W_MAX
) (
  input  wire logic                 aclk,
  input  wire logic                 i_rst,
  input  wire logic                 i_clear,
  input  wire logic                 i_wen,
  input  wire logic [DATA_W-1:0]    i_wdata,
  input  wire logic [BITS_ADDR-1:0] i_last_addr,
  output logic                      o_full,
  input  wire logic                 i_rready,
  output logic [DATA_W-1:0]         o_rdata,
  output logic                      o_rvalid
);

  logic [DATA_W-1:0]    mem [BANK_DEPTH];
  logic [BITS_ADDR-1:0] wptr;
  logic [BITS_ADDR-1:0] raddr;
  logic                 last_write;
  logic                 advance;

  assign last_write = i_wen && (wptr == i_last_addr);
  assign o_full     = last_write;
  assign advance    = i_rready && o_rvalid;

  always_ff @(posedge aclk) begin
    if (i_wen) begin
      mem[wptr] <= i_wdata;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst || i_clear) begin
      wptr <= '0;
    end else if (i_wen && !last_write) begin
      wptr <= wptr + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word 0 is fetched on the final write, so it is valid the next cycle.
  // raddr always points at the word after the one on o_rdata
  always_ff @(posedge aclk) begin
    if (i_rst || i_clear) begin
      o_rvalid <= 1'b0;
      raddr    <= '0;
    end else if (last_write) begin
      o_rvalid <= 1'b1;
      raddr    <= (i_last_addr == '0) ? '0 : BITS_ADDR'(1);
    end else if (advance) begin
      raddr <= (raddr == i_last_addr) ? '0 : raddr + 1'b1;
    end
  end

  // A single-word bank writes address 0 on the same edge, so bypass it
  always_ff @(posedge aclk) begin
    if (last_write) begin
      o_rdata <= (wptr == '0) ? i_wdata : mem[0];
    end else if (advance) begin
      o_rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/weight_rotator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight rotator top with ping-pong banks and output mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module weight_rotator
  import rotator_pkg::*;
#(
  parameter int  CORES      = 2,
  parameter int  WORD_WIDTH = 8,
  localparam int DATA_W     = WORD_WIDTH * CORES * KERNEL_W_MAX
) (
  input  wire logic              aclk,
  input  wire logic              i_rst,
  input  wire logic              i_s_valid,
  output logic                   o_s_ready,
  input  wire logic [DATA_W-1:0] i_s_data,
  output logic                   o_m_valid,
  input  wire logic              i_m_ready,
  output logic [DATA_W-1:0]      o_m_data,
  output logic                   o_m_last,
  output user_t                  o_m_user
);

  header_t [1:0]             headers;
  logic [1:0]                done_read;
  logic [1:0]                done_write;
  logic [1:0]                bank_clear;
  logic [1:0]                bank_wen;
  logic [1:0]                bank_full;
  logic [1:0]                bank_rready;
  logic [1:0]                bank_rvalid;
  logic [1:0][BITS_ADDR-1:0] last_addr;
  logic [DATA_W-1:0]         bank_rdata [2];
  logic                      read_bank;

  write_ctrl #(
    .CORES      (CORES),
    .WORD_WIDTH (WORD_WIDTH)
  ) u_write (
    .aclk         (aclk),
    .i_rst        (i_rst),
    .i_s_valid    (i_s_valid),
    .o_s_ready    (o_s_ready),
    .i_s_data     (i_s_data),
    .i_done_read  (done_read),
    .o_done_write (done_write),
    .o_headers    (headers),
    .o_clear      (bank_clear),
    .o_wen        (bank_wen),
    .o_last_addr  (last_addr),
    .i_full       (bank_full),
    .i_rvalid     (bank_rvalid)
  );

  read_ctrl u_read (
    .aclk         (aclk),
    .i_rst        (i_rst),
    .i_done_write (done_write),
    .o_done_read  (done_read),
    .i_headers    (headers),
    .i_m_ready    (i_m_ready),
    .o_m_valid    (o_m_valid),
    .o_m_last     (o_m_last),
    .o_m_user     (o_m_user),
    .o_rready     (bank_rready),
    .o_read_bank  (read_bank)
  );

  for (genvar b = 0; b < 2; b++) begin : g_bank
    weight_bank #(
      .CORES      (CORES),
      .WORD_WIDTH (WORD_WIDTH)
    ) u_bank (
      .aclk        (aclk),
      .i_rst       (i_rst),
      .i_clear     (bank_clear[b]),
      .i_wen       (bank_wen[b]),
      .i_wdata     (i_s_data),
      .i_last_addr (last_addr[b]),
      .o_full      (bank_full[b]),
      .i_rready    (bank_rready[b]),
      .o_rdata     (bank_rdata[b]),
      .o_rvalid    (bank_rvalid[b])
    );
  end

  assign o_m_data = bank_rdata[read_bank];

endmodule

`default_nettype wire

// File: rtl/write_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write FSM, write bank index, done_write flags and header registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module write_ctrl
  import rotator_pkg::*;
#(
  parameter int  CORES      = 2,
  parameter int  WORD_WIDTH = 8,
  localparam int DATA_W     = WORD_WIDTH * CORES * KERNEL_W_MAX
) (
  input  wire logic              aclk,
  input  wire logic              i_rst,
  input  wire logic              i_s_valid,
  output logic                   o_s_ready,
  input  wire logic [DATA_W-1:0] i_s_data,
  input  wire logic [1:0]        i_done_read,
  output logic [1:0]             o_done_write,
  output header_t [1:0]          o_headers,
  output logic [1:0]             o_clear,
  output logic [1:0]             o_wen,
  output logic [1:0][BITS_ADDR-1:0] o_last_addr,
  input  wire logic [1:0]        i_full,
  input  wire logic [1:0]        i_rvalid
);

  write_state_e state;
  write_state_e state_next;
  logic         wr_idx;
  logic         header_hs;

  // Last word address of a bank is (kh_1+1)*(cin_1+1)-1
  function automatic logic [BITS_ADDR-1:0] calc_last_addr(header_t h);
    logic [BITS_ADDR-1:0] rows;
    logic [BITS_ADDR-1:0] chans;
    rows  = BITS_ADDR'(h.kh_1) + 1'b1;
    chans = BITS_ADDR'(h.cin_1) + 1'b1;
    return BITS_ADDR'(rows * chans - 1'b1);
  endfunction

  assign o_s_ready = (state == W_GET_REF) || (state == W_WRITE);
  assign header_hs = i_s_valid && (state == W_GET_REF);

  always_comb begin
    state_next = state;
    unique case (state)
      W_IDLE:    if (i_done_read[wr_idx]) state_next = W_GET_REF;
      W_GET_REF: if (i_s_valid) state_next = W_WRITE;
      W_WRITE:   if (i_full[wr_idx]) state_next = W_FILL;
      W_FILL:    if (i_rvalid[wr_idx]) state_next = W_SWITCH;
      W_SWITCH:  state_next = W_IDLE;
      default:   state_next = W_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state        <= W_IDLE;
      wr_idx       <= 1'b0;
      o_done_write <= '0;
    end else begin
      state <= state_next;
      // The reader must not see this bank as ready while it is refilled
      if (state == W_GET_REF) begin
        o_done_write[wr_idx] <= 1'b0;
      end
      if (state == W_SWITCH) begin
        o_done_write[wr_idx] <= 1'b1;
        wr_idx               <= ~wr_idx;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (header_hs) begin
      o_headers[wr_idx] <= header_t'(i_s_data[$bits(header_t)-1:0]);
    end
  end

  for (genvar b = 0; b < 2; b++) begin : g_bank
    assign o_clear[b]     = header_hs && (wr_idx == 1'(b));
    assign o_wen[b]       = i_s_valid && (state == W_WRITE) && (wr_idx == 1'(b));
    assign o_last_addr[b] = calc_last_addr(o_headers[b]);
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the weight rotator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_weight_rotator -f all.f -o sim_weight_rotator
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_weight_rotator +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: verification/rotator_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream protocol assertions bound to the weight rotator top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rotator_checker
  import rotator_pkg::*;
#(
  parameter int DATA_W = 48
) (
  input wire logic              aclk,
  input wire logic              i_rst,
  input wire logic              o_s_ready,
  input wire logic              o_m_valid,
  input wire logic              i_m_ready,
  input wire logic [DATA_W-1:0] o_m_data,
  input wire logic              o_m_last,
  input wire user_t             o_m_user
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // A stalled beat stays on the bus unchanged until it is taken
  assert property (@(posedge aclk) disable iff (i_rst)
    o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data) &&
                                $stable(o_m_last) && $stable(o_m_user))
  else begin
    fail_count++;
    $error("output beat changed or dropped while the sink stalled");
  end

  // The reset takes effect on its first edge
  assert property (@(posedge aclk) i_rst && $past(i_rst) |-> !o_m_valid && !o_s_ready)
  else begin
    fail_count++;
    $error("stream valid or ready high during reset");
  end

  assert property (@(posedge aclk) disable iff (i_rst) o_m_last |-> o_m_valid)
  else begin
    fail_count++;
    $error("output last high without output valid");
  end

endmodule

bind weight_rotator rotator_checker #(
  .DATA_W (DATA_W)
) u_checker (
  .aclk      (aclk),
  .i_rst     (i_rst),
  .o_s_ready (o_s_ready),
  .o_m_valid (o_m_valid),
  .i_m_ready (i_m_ready),
  .o_m_data  (o_m_data),
  .o_m_last  (o_m_last),
  .o_m_user  (o_m_user)
);

`default_nettype wire

// File: verification/tb_weight_rotator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight rotator testbench with frame driver, reference queues and scoreboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_weight_rotator
  import rotator_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CORES      = 2;
  localparam int WORD_WIDTH = 8;
  localparam int DATA_W     = WORD_WIDTH * CORES * KERNEL_W_MAX;
  localparam int N_FRAMES   = 8;

  logic              aclk;
  logic              i_rst;
  logic              i_s_valid;
  logic              o_s_ready;
  logic [DATA_W-1:0] i_s_data;
  logic              o_m_valid;
  logic              i_m_ready = 1'b1;
  logic [DATA_W-1:0] o_m_data;
  logic              o_m_last;
  user_t             o_m_user;

  integer            seed         = 32'h7cf5_765e;
  integer            ready_seed   = 32'h7cf5_765e;
  logic              ready_random = 1'b0;
  header_t           frames [N_FRAMES];
  logic [DATA_W-1:0] exp_data [$];
  user_t             exp_user [$];
  bit                exp_last [$];
  int                exp_total     = 0;
  int                out_count     = 0;
  int                frames_done   = 0;
  int                errors        = 0;
  int                hold_errors   = 0;
  int                cycles        = 0;
  int                timeout_limit = 0;
  int                beats_seen    = 0;
  int                errs_seen     = 0;

  weight_rotator #(
    .CORES      (CORES),
    .WORD_WIDTH (WORD_WIDTH)
  ) uut (
    .aclk      (aclk),
    .i_rst     (i_rst),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  initial aclk = 1'b0;
  always #4 aclk = ~aclk;

  function automatic header_t make_header(int blocks_1, int cols_1, int cin_1, int kh_1,
                                          int kw_1);
    header_t h;
    h.blocks_1 = BITS_BLOCKS'(blocks_1);
    h.cols_1   = BITS_COLS'(cols_1);
    h.cin_1    = BITS_CIN'(cin_1);
    h.kh_1     = BITS_KH'(kh_1);
    h.kw_1     = BITS_KW'(kw_1);
    return h;
  endfunction

  function automatic int frame_words(header_t h);
    return (int'(h.kh_1) + 1) * (int'(h.cin_1) + 1);
  endfunction

  function automatic int frame_reps(header_t h);
    return (int'(h.cols_1) + 1) * (int'(h.blocks_1) + 1);
  endfunction

  // Repetition rep walks the columns first, then the blocks
  function automatic user_t expect_user(header_t h, int rep);
    int    col;
    int    blk;
    user_t u;
    col            = rep % (int'(h.cols_1) + 1);
    blk            = rep / (int'(h.cols_1) + 1);
    u.kw_1         = h.kw_1;
    u.kh_1         = h.kh_1;
    u.is_1x1       = (h.kw_1 == '0);
    u.is_top       = (blk == 0);
    u.is_bottom    = (blk == int'(h.blocks_1));
    u.is_cols_1_k2 = ((int'(h.cols_1) - col) == (int'(h.kw_1) / 2));
    return u;
  endfunction

  function automatic int total_errors();
    return errors + hold_errors + uut.u_checker.fail_count;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Source side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_beat(input logic [DATA_W-1:0] data, input bit gaps);
    if (gaps && (($random(seed) & 1) != 0)) begin
      i_s_valid <= 1'b0;
      @(posedge aclk);
    end
    i_s_valid <= 1'b1;
    i_s_data  <= data;
    @(posedge aclk);
    while (!o_s_ready) begin
      @(posedge aclk);
    end
  endtask

  // A need_done of -1 skips the check on the header handshake
  task automatic send_frame(input header_t h, input bit gaps, input int need_done);
    logic [DATA_W-1:0] words [$];
    for (int w = 0; w < frame_words(h); w++) begin
      words.push_back(DATA_W'({$random(seed), $random(seed)}));
    end
    for (int r = 0; r < frame_reps(h); r++) begin
      for (int w = 0; w < frame_words(h); w++) begin
        exp_data.push_back(words[w]);
        exp_user.push_back(expect_user(h, r));
        exp_last.push_back(r == frame_reps(h) - 1 && w == frame_words(h) - 1);
      end
    end
    exp_total += frame_words(h) * frame_reps(h);
    drive_beat(DATA_W'(h), gaps);
    if (need_done >= 0) begin
      assert (frames_done >= need_done) else begin
        hold_errors++;
        $display("Header taken at %0t ns while both banks still held unread frames", $time);
      end
    end
    foreach (words[i]) begin
      drive_beat(words[i], gaps);
    end
    i_s_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (out_count != exp_total) begin
      @(posedge aclk);
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s finished: %0d beats, %0d errors", num, name,
             out_count - beats_seen, total_errors() - errs_seen);
    beats_seen = out_count;
    errs_seen  = total_errors();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sink side and scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge aclk) begin
    i_m_ready <= ready_random ? (($random(ready_seed) & 3) != 0) : 1'b1;
  end

  always @(posedge aclk) begin : scoreboard
    logic [DATA_W-1:0] want_data;
    user_t             want_user;
    bit                want_last;
    if (!i_rst && o_m_valid && i_m_ready) begin
      out_count <= out_count + 1;
      if (o_m_last) begin
        frames_done <= frames_done + 1;
      end
      if (exp_data.size() == 0) begin
        errors++;
        $display("Output beat at %0t ns arrived with no frame left to expect", $time);
      end else begin
        want_data = exp_data.pop_front();
        want_user = exp_user.pop_front();
        want_last = exp_last.pop_front();
        assert (o_m_data == want_data) else begin
          errors++;
          $display("** Error @ %0t ns: data %h, expected %h", $time, o_m_data, want_data);
        end
        assert (o_m_last == want_last) else begin
          errors++;
          $display("** Error @ %0t ns: last %b, expected %b", $time, o_m_last, want_last);
        end
        assert (o_m_user == want_user) else begin
          errors++;
          $display("** Error @ %0t ns: user %h, expected %h", $time, o_m_user, want_user);
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    int need;
    i_rst     = 1'b1;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    frames[0] = make_header(2, 3, 3, 2, 2);
    frames[1] = make_header(1, 2, 0, 0, 0);
    frames[2] = make_header(0, 1, 2, 1, 2);
    frames[3] = make_header(1, 3, 1, 2, 2);
    frames[4] = make_header(0, 0, 3, 0, 0);
    frames[5] = make_header(1, 1, 0, 2, 2);
    frames[6] = make_header(3, 2, 4, 1, 2);
    frames[7] = make_header(1, 1, 1, 0, 0);
    foreach (frames[i]) begin
      timeout_limit += 4 * frame_words(frames[i]) * frame_reps(frames[i]);
    end
    timeout_limit += 2000;
    repeat (16) @(posedge aclk);
    i_rst <= 1'b0;

    send_frame(frames[0], 1'b0, -1);
    wait_drain();
    report_test(1, "single 3x3 frame");

    // Single-word 1x1 bank followed at once by a frame of another size
    send_frame(frames[1], 1'b0, -1);
    send_frame(frames[2], 1'b0, -1);
    wait_drain();
    report_test(2, "1x1 then 3x2 frame");

    // The third frame must wait for the first bank to be read out
    need = frames_done + 1;
    send_frame(frames[3], 1'b0, -1);
    send_frame(frames[4], 1'b0, -1);
    send_frame(frames[5], 1'b0, need);
    wait_drain();
    report_test(3, "three queued frames");

    ready_random <= 1'b1;
    send_frame(frames[6], 1'b1, -1);
    send_frame(frames[7], 1'b1, -1);
    wait_drain();
    ready_random <= 1'b0;
    report_test(4, "random back-pressure");

    repeat (4) @(posedge aclk);
    $display("Summary: 4 tests, %0d of %0d beats checked, %0d errors",
             out_count, exp_total, total_errors());
    if (total_errors() == 0 && out_count == exp_total) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
